//--- flist.f
+incdir+src
src/ps2_kbd_pkg.sv
src/key_fifo_if.sv
src/ps2_rx.sv
src/key_fifo.sv
src/scan_to_seg.sv
src/key_display.sv
src/ps2_kbd_top.sv
dv/ps2_kbd_tb.sv

//--- Makefile
# Verilator build and run for the PS/2 keyboard display design

VERILATOR ?= verilator
TOP       ?= ps2_kbd_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard src/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q '^Test passed$$' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/ps2_kbd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_kbd_tb;

  localparam int HALF_BIT = 20;  // System cycles per PS/2 clock phase
  localparam int SETTLE = 20;    // Cycles after a frame before checking
  localparam int FRAME_CYCLES = 11 * (2 * HALF_BIT + 1) + 1;
  localparam int NUM_FRAMES = 56;  // 19 mapped, 20 random, 5 prefix, 3 error, 9 freeze
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * (FRAME_CYCLES + SETTLE) + 1000;

  logic                    clk;
  logic                    reset;
  logic                    ps2_clk;
  logic                    ps2_data;
  logic                    freeze;
  ps2_kbd_pkg::seg_t       seg;
  logic                    seg_valid;
  logic                    fifo_full;
  logic                    frame_error;

  // Reference model state
  ps2_kbd_pkg::seg_t       exp_seg;
  logic                    exp_valid;
  logic                    exp_full;
  int                      exp_errs;
  ps2_kbd_pkg::disp_state_t model_state;
  ps2_kbd_pkg::scan_code_t pending [$];  // Bytes held in the FIFO while frozen

  ps2_kbd_pkg::scan_code_t mapped_codes [19];
  ps2_kbd_pkg::scan_code_t code;
  logic [31:0]             rnd;
  int                      err_count = 0;
  int                      cycle_count = 0;
  int                      checks_sent = 0;
  int                      checks_done = 0;
  event                    check_ev;

  ps2_kbd_top uut (
    .clk         (clk),
    .reset       (reset),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .freeze      (freeze),
    .seg         (seg),
    .seg_valid   (seg_valid),
    .fifo_full   (fifo_full),
    .frame_error (frame_error)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Expected pattern from the digit and letter shapes, lit segments first
  function automatic ps2_kbd_pkg::seg_t ref_seg(input ps2_kbd_pkg::scan_code_t sc);
    logic [6:0] lit;  // Active high, gfedcba
    case (sc)
      8'h45:   lit = 7'b0111111;  // 0
      8'h16:   lit = 7'b0000110;
      8'h1E:   lit = 7'b1011011;
      8'h26:   lit = 7'b1001111;
      8'h25:   lit = 7'b1100110;
      8'h2E:   lit = 7'b1101101;
      8'h36:   lit = 7'b1111101;
      8'h3D:   lit = 7'b0000111;
      8'h3E:   lit = 7'b1111111;
      8'h46:   lit = 7'b1101111;  // 9
      8'h1C:   lit = 7'b1110111;  // A
      8'h21:   lit = 7'b0111001;  // C
      8'h24:   lit = 7'b1111001;  // E
      8'h2B:   lit = 7'b1110001;  // F
      8'h33:   lit = 7'b1110110;  // H
      8'h3B:   lit = 7'b0001110;  // J, hook without segment e
      8'h4B:   lit = 7'b0111000;  // L
      8'h4D:   lit = 7'b1110011;  // P
      8'h3C:   lit = 7'b0111110;  // U
      default: lit = 7'b0000000;
    endcase
    return ~lit;
  endfunction

  task automatic report_failure(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_seg(input ps2_kbd_pkg::seg_t got, input ps2_kbd_pkg::seg_t exp);
    if (got !== exp) begin
      report_failure($sformatf("seg is %b, expected %b", got, exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  // Make/break/extended rule applied to one byte that reached the display
  task automatic apply_byte(input ps2_kbd_pkg::scan_code_t sc);
    if (sc == ps2_kbd_pkg::SCAN_BREAK) begin
      model_state = ps2_kbd_pkg::DISP_BREAK;
    end else if (sc == ps2_kbd_pkg::SCAN_EXT) begin
      model_state = model_state;
    end else if (model_state == ps2_kbd_pkg::DISP_BREAK) begin
      model_state = ps2_kbd_pkg::DISP_IDLE;  // Released key
    end else begin
      model_state = ps2_kbd_pkg::DISP_MAKE;
      exp_seg = ref_seg(sc);
      exp_valid = 1'b1;
    end
  endtask

  // Device side of one frame, data changes while ps2_clk is high
  task automatic send_frame(input ps2_kbd_pkg::scan_code_t sc, input logic bad_parity,
                            input logic bad_start, input logic bad_stop);
    logic [10:0] bits;
    bits[0] = bad_start;
    bits[8:1] = sc;
    bits[9] = ~(^sc) ^ bad_parity;  // Odd parity over data and parity
    bits[10] = ~bad_stop;
    for (int i = 0; i < 11; i++) begin
      @(negedge clk);
      ps2_data = bits[i];
      repeat (HALF_BIT) @(negedge clk);
      ps2_clk = 1'b0;
      repeat (HALF_BIT) @(negedge clk);
      ps2_clk = 1'b1;
    end
    @(negedge clk);
    ps2_data = 1'b1;  // Back to idle
  endtask

  task automatic request_check();
    checks_sent++;
    -> check_ev;
  endtask

  task automatic send_and_check(input ps2_kbd_pkg::scan_code_t sc, input logic bad_parity,
                                input logic bad_start, input logic bad_stop);
    send_frame(sc, bad_parity, bad_start, bad_stop);
    if (bad_parity || bad_start || bad_stop) begin
      exp_errs++;
    end else if (freeze) begin
      if (pending.size() < 7) begin
        pending.push_back(sc);  // Otherwise dropped at the FIFO
      end
    end else begin
      apply_byte(sc);
    end
    exp_full = freeze && (pending.size() >= 7);
    repeat (SETTLE) @(negedge clk);
    request_check();
  endtask

  // Scoreboard compare
  always @(check_ev) begin
    check_seg(seg, exp_seg);
    check_bit("seg_valid", seg_valid, exp_valid);
    check_bit("fifo_full", fifo_full, exp_full);
    check_bit("frame error count matches", err_count == exp_errs, 1'b1);
    checks_done++;
  end

  always @(negedge clk) begin
    if (!reset && frame_error) begin
      err_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: simulation timed out after %0d cycles", cycle_count);
      $display("Test failed");
      $fatal(1, "simulation timed out");
    end
  end

  initial begin
    rnd = $urandom(32'h52f2);  // Seed once
    reset = 1'b1;
    ps2_clk = 1'b1;
    ps2_data = 1'b1;
    freeze = 1'b0;
    exp_seg = '1;
    exp_valid = 1'b0;
    exp_full = 1'b0;
    exp_errs = 0;
    model_state = ps2_kbd_pkg::DISP_IDLE;
    mapped_codes = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46,
                     8'h1C, 8'h21, 8'h24, 8'h2B, 8'h33, 8'h3B, 8'h4B, 8'h4D, 8'h3C};
    repeat (5) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);
    request_check();  // Values straight after reset

    for (int i = 0; i < 19; i++) begin
      send_and_check(mapped_codes[i], 1'b0, 1'b0, 1'b0);
    end
    for (int n = 0; n < 20; n++) begin
      do begin
        rnd = $urandom();
        code = rnd[7:0];
      end while (ref_seg(code) != 7'h7F || code == ps2_kbd_pkg::SCAN_BREAK ||
                 code == ps2_kbd_pkg::SCAN_EXT);
      send_and_check(code, 1'b0, 1'b0, 1'b0);
    end

    // Break prefix and extended prefix
    send_and_check(ps2_kbd_pkg::SCAN_BREAK, 1'b0, 1'b0, 1'b0);
    send_and_check(8'h1C, 1'b0, 1'b0, 1'b0);  // Released A, no change
    send_and_check(8'h33, 1'b0, 1'b0, 1'b0);
    send_and_check(ps2_kbd_pkg::SCAN_EXT, 1'b0, 1'b0, 1'b0);
    send_and_check(8'h4D, 1'b0, 1'b0, 1'b0);

    // One bad field per frame
    send_and_check(8'h16, 1'b1, 1'b0, 1'b0);
    send_and_check(8'h16, 1'b0, 1'b1, 1'b0);
    send_and_check(8'h16, 1'b0, 1'b0, 1'b1);

    // Fill the FIFO while the display is held
    @(negedge clk);
    freeze = 1'b1;
    send_and_check(8'h16, 1'b0, 1'b0, 1'b0);
    send_and_check(8'h1E, 1'b0, 1'b0, 1'b0);
    send_and_check(8'h26, 1'b0, 1'b0, 1'b0);
    send_and_check(8'h25, 1'b0, 1'b0, 1'b0);
    send_and_check(8'h2E, 1'b0, 1'b0, 1'b0);
    send_and_check(8'h36, 1'b0, 1'b0, 1'b0);
    send_and_check(8'h3D, 1'b0, 1'b0, 1'b0);  // Seventh, FIFO now full
    send_and_check(8'h3E, 1'b0, 1'b0, 1'b0);
    send_and_check(8'h46, 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    freeze = 1'b0;
    foreach (pending[i]) begin
      apply_byte(pending[i]);
    end
    pending.delete();
    exp_full = 1'b0;
    repeat (SETTLE) @(negedge clk);
    request_check();

    @(negedge clk);
    if (checks_done == checks_sent) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("ERROR: only %0d of %0d checks ran", checks_done, checks_sent);
      $display("Test failed");
      $fatal(1, "check count mismatch");
    end
  end

endmodule

`default_nettype wire

//--- src/ps2_kbd_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps2_kbd_defs.svh"

module ps2_kbd_top (
  input  wire               clk,
  input  wire               reset,
  input  wire               ps2_clk,
  input  wire               ps2_data,
  input  wire               freeze,
  output ps2_kbd_pkg::seg_t seg,
  output logic              seg_valid,
  output logic              fifo_full,
  output logic              frame_error
);

  logic                    byte_valid;
  ps2_kbd_pkg::scan_code_t rx_byte;

  key_fifo_if fifo_if ();

  ps2_rx u_rx (
    .clk         (clk),
    .reset       (reset),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .byte_valid  (byte_valid),
    .rx_byte     (rx_byte),
    .frame_error (frame_error)
  );

  key_fifo #(
    .AW (`KBD_FIFO_AW)
  ) u_fifo (
    .clk        (clk),
    .reset      (reset),
    .byte_valid (byte_valid),
    .rx_byte    (rx_byte),
    .rd         (fifo_if.fifo)
  );

  key_display u_disp (
    .clk       (clk),
    .reset     (reset),
    .freeze    (freeze),
    .rd        (fifo_if.disp),
    .seg       (seg),
    .seg_valid (seg_valid)
  );

  assign fifo_full = fifo_if.full;

endmodule

`default_nettype wire

//--- src/key_display.sv
`timescale 1ns/1ps
`default_nettype none

module key_display (
  input  wire               clk,
  input  wire               reset,
  input  wire               freeze,
  key_fifo_if.disp          rd,
  output ps2_kbd_pkg::seg_t seg,
  output logic              seg_valid
);

  ps2_kbd_pkg::disp_state_t state;
  ps2_kbd_pkg::scan_code_t  byte_q;   // Last popped byte
  logic                     read_q;   // byte_q is fresh this cycle
  ps2_kbd_pkg::seg_t        seg_xlat;

  // At most one pop every other cycle
  assign rd.read = rd.ready & ~freeze & ~read_q;

  scan_to_seg u_xlat (
    .code (byte_q),
    .seg  (seg_xlat)
  );

  always_ff @(posedge clk) begin
    if (rd.read) begin
      byte_q <= rd.code;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      read_q    <= 1'b0;
      state     <= ps2_kbd_pkg::DISP_IDLE;
      seg       <= '1;
      seg_valid <= 1'b0;
    end else begin
      read_q <= rd.read;
      if (read_q) begin
        if (byte_q == ps2_kbd_pkg::SCAN_BREAK) begin
          state <= ps2_kbd_pkg::DISP_BREAK;
        end else if (byte_q == ps2_kbd_pkg::SCAN_EXT) begin
          state <= state;  // Prefix dropped, no meaning kept
        end else if (state == ps2_kbd_pkg::DISP_BREAK) begin
          state <= ps2_kbd_pkg::DISP_IDLE;  // Released key, discard
        end else begin
          state     <= ps2_kbd_pkg::DISP_MAKE;
          seg       <= seg_xlat;
          seg_valid <= 1'b1;
        end
      end
    end
  end

  // Pops only a non-empty FIFO, and never back to back
  a_read_rule: assert property (@(posedge clk) disable iff (reset)
    rd.read |-> rd.ready ##1 !rd.read);

endmodule

`default_nettype wire

//--- src/scan_to_seg.sv
`timescale 1ns/1ps
`default_nettype none

module scan_to_seg (
  input  wire ps2_kbd_pkg::scan_code_t code,
  output ps2_kbd_pkg::seg_t            seg
);

  // Set-2 make codes, pattern is gfedcba with 0 lighting a segment
  always_comb begin
    case (code)
      8'h45:   seg = 7'b1000000;  // 0
      8'h16:   seg = 7'b1111001;
      8'h1E:   seg = 7'b0100100;
      8'h26:   seg = 7'b0110000;
      8'h25:   seg = 7'b0011001;
      8'h2E:   seg = 7'b0010010;
      8'h36:   seg = 7'b0000010;
      8'h3D:   seg = 7'b1111000;
      8'h3E:   seg = 7'b0000000;
      8'h46:   seg = 7'b0010000;  // 9
      8'h1C:   seg = 7'b0001000;  // A
      8'h21:   seg = 7'b1000110;  // C
      8'h24:   seg = 7'b0000110;  // E
      8'h2B:   seg = 7'b0001110;  // F
      8'h33:   seg = 7'b0001001;  // H
      8'h3B:   seg = 7'b1110001;  // J
      8'h4B:   seg = 7'b1000111;  // L
      8'h4D:   seg = 7'b0001100;  // P
      8'h3C:   seg = 7'b1000001;  // U
      default: seg = 7'b1111111;  // Blank
    endcase
  end

endmodule

`default_nettype wire

//--- src/key_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps2_kbd_defs.svh"

module key_fifo #(
  parameter int AW = `KBD_FIFO_AW
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     byte_valid,
  input  wire ps2_kbd_pkg::scan_code_t rx_byte,
  key_fifo_if.fifo                rd
);

  ps2_kbd_pkg::scan_code_t mem [2**AW];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          wr_en;
  logic          rd_en;

  assign rd.full  = (AW'(wr_ptr + 1'b1) == rd_ptr);  // One slot kept free
  assign rd.ready = (wr_ptr != rd_ptr);
  assign rd.code  = mem[rd_ptr];  // Head shown without a read

  // Overflowing bytes are simply lost
  assign wr_en = byte_valid & ~rd.full;
  assign rd_en = rd.read & rd.ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= rx_byte;
    end
  end

  // The display must never pop an empty FIFO
  a_no_empty_read: assert property (@(posedge clk) disable iff (reset)
    rd.read |-> rd.ready);

  // With one move per pointer per cycle, full to empty or empty to full
  // in a single step would mean a pointer passed the other
  a_no_overtake: assert property (@(posedge clk) disable iff (reset)
    (rd.full |=> rd.ready) and (!rd.ready |=> !rd.full));

endmodule

`default_nettype wire

//--- src/ps2_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "ps2_kbd_defs.svh"

module ps2_rx (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     ps2_clk,
  input  wire                     ps2_data,
  output logic                    byte_valid,
  output ps2_kbd_pkg::scan_code_t rx_byte,
  output logic                    frame_error
);

  localparam int SL = `PS2_SYNC_LEN;
  localparam int CW = $clog2(`PS2_FRAME_BITS);

  logic [SL-1:0]        clk_sync;  // ps2_clk history, newest in bit 0
  logic                 fall;
  logic [CW-1:0]        bit_cnt;
  ps2_kbd_pkg::frame_t  frame;
  logic                 last_bit;
  logic                 frame_ok;

  // Falling edge seen at the far end of the synchronizer
  assign fall = clk_sync[SL-1] & ~clk_sync[SL-2];

  assign last_bit = (bit_cnt == CW'(`PS2_FRAME_BITS - 1));

  // frame[0] start, frame[9] parity, ps2_data is the stop bit right now
  assign frame_ok = ~frame[0] & ps2_data & (^frame[9:1]);

  always_ff @(posedge clk) begin
    if (reset) begin
      clk_sync    <= '1;  // Idle line is high
      bit_cnt     <= '0;
      byte_valid  <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      clk_sync    <= {clk_sync[SL-2:0], ps2_clk};
      byte_valid  <= 1'b0;
      frame_error <= 1'b0;
      if (fall) begin
        if (last_bit) begin
          bit_cnt     <= '0;
          byte_valid  <= frame_ok;
          frame_error <= ~frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // Frame bits enter at the top and move toward bit 0
  always_ff @(posedge clk) begin
    if (fall && !last_bit) begin
      frame <= {ps2_data, frame[9:1]};
    end
    if (fall && last_bit) begin
      rx_byte <= frame[8:1];  // Data bits, LSB first on the wire
    end
  end

  // A finished frame is either good or bad, never both
  a_one_result: assert property (@(posedge clk) disable iff (reset)
    !(byte_valid && frame_error));

endmodule

`default_nettype wire

//--- src/key_fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface key_fifo_if;

  logic                    ready;  // FIFO holds at least one code
  ps2_kbd_pkg::scan_code_t code;   // Head entry
  logic                    full;   // No room for another byte
  logic                    read;   // Pop strobe from the consumer

  // FIFO side
  modport fifo (
    output ready,
    output code,
    output full,
    input  read
  );

  // Display side
  modport disp (
    input  ready,
    input  code,
    output read
  );

endinterface

`default_nettype wire

//--- src/ps2_kbd_pkg.sv
`default_nettype none

package ps2_kbd_pkg;

  typedef logic [7:0] scan_code_t;  // One set-2 scan code byte

  typedef logic [6:0] seg_t;  // Active low, bit 0 is segment a

  // Start bit in bit 0, parity bit in bit 9
  typedef logic [9:0] frame_t;

  // Prefix tracking in the display controller
  typedef enum logic [1:0] {
    DISP_IDLE,   // Nothing shown yet or key released
    DISP_MAKE,   // Last byte was a make code
    DISP_BREAK   // F0 seen, next byte is the released key
  } disp_state_t;

  localparam scan_code_t SCAN_BREAK = 8'hF0;  // Key release prefix
  localparam scan_code_t SCAN_EXT = 8'hE0;    // Extended key prefix

endpackage

`default_nettype wire

//--- src/ps2_kbd_defs.svh
`ifndef PS2_KBD_DEFS_SVH
`define PS2_KBD_DEFS_SVH

// log2 of the key FIFO depth, one slot always stays free
`define KBD_FIFO_AW 3

// Flops on the ps2_clk line before edge detection
`define PS2_SYNC_LEN 3

// Start, 8 data, parity, stop
`define PS2_FRAME_BITS 11

`endif
